/* all.f */
hw/rvc_pkg.sv
hw/fetch_counter.sv
hw/halfword_aligner.sv
hw/rvc_expander.sv
hw/fetch_top.sv
bench/tb_fetch.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_fetch
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx '>>> PASS' $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_fetch.sv */
`timescale 1ns/10ps

module tb_fetch;

    localparam int ROM_WORDS    = 1 << rvc_pkg::ADDR_W;
    localparam int N_WIDE       = 16;
    localparam int N_MIXED      = 400;
    localparam int N_TAIL       = 8;
    localparam int RESET_CYCLES = 10;
    localparam int RUN_LIMIT    = 4000;
    localparam int DRAIN_CYCLES = 4;

    logic                       clk;
    logic                       nrst;
    logic                       run;
    logic [rvc_pkg::ADDR_W-1:0] imem_addr;
    logic [rvc_pkg::XLEN-1:0]   imem_data;
    rvc_pkg::decoded_inst_t     out_inst;

    logic [rvc_pkg::XLEN-1:0]   rom [0:ROM_WORDS-1];
    logic [rvc_pkg::HALF-1:0]   halves [$];
    rvc_pkg::decoded_inst_t     exp_q [$];
    logic                       run_q;
    logic                       checking;
    int                         n_seen;
    int                         n_prog;
    int                         n_halves;

    fetch_top i_dut (
        .clk       (clk),
        .nrst      (nrst),
        .run       (run),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .out_inst  (out_inst)
    );

    // instruction memory answers in the same cycle.
    assign imem_data = rom[imem_addr];

    always #10 clk = ~clk;

    // run as the DUT sampled it at the last edge.
    always @(posedge clk) begin
        run_q <= run;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic add_word(input logic [rvc_pkg::XLEN-1:0] w);
        halves.push_back(w[15:0]);
        halves.push_back(w[31:16]);
        exp_q.push_back({1'b1, 1'b0, 1'b0, w});
    endtask

    task automatic add_half(input logic [15:0] h, input logic [31:0] inst, input logic illegal);
        halves.push_back(h);
        exp_q.push_back({1'b1, 1'b1, illegal, inst});
    endtask

    // random instruction stream, 32-bit only at first, then mixed, then a 32-bit tail.
    task automatic build_program();
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [5:0]  imm;
        logic [11:0] imm12;
        logic [31:0] w;
        for (int a = 0; a < ROM_WORDS; a++) begin
            rom[a] = {a[24:0], 7'b0010011};
        end
        for (int i = 0; i < N_WIDE + N_MIXED + N_TAIL; i++) begin
            rd    = 5'($urandom);
            rs2   = 5'($urandom_range(31, 1));
            imm   = 6'($urandom);
            imm12 = {{6{imm[5]}}, imm};
            w     = $urandom;
            kind  = (i < N_WIDE || i >= N_WIDE + N_MIXED) ? 0 : $urandom_range(13, 0);
            case (kind)
                5, 11: add_half({3'b000, imm[5], rd, imm[4:0], 2'b01},
                                {imm12, rd, 3'b000, rd, 7'b0010011}, 1'b0);
                6, 12: add_half({3'b010, imm[5], rd, imm[4:0], 2'b01},
                                {imm12, 5'd0, 3'b000, rd, 7'b0010011}, 1'b0);
                7: begin
                    // x0 and x2 are not lui targets, and the immediate must be nonzero.
                    if (rd == 5'd0 || rd == 5'd2) begin
                        rd = rd + 5'd1;
                    end
                    if (imm == 6'd0) begin
                        imm = 6'h20;
                    end
                    add_half({3'b011, imm[5], rd, imm[4:0], 2'b01},
                             {{14{imm[5]}}, imm, rd, 7'b0110111}, 1'b0);
                end
                8: add_half({3'b000, 1'b0, rd, imm[4:0], 2'b10},
                            {7'd0, imm[4:0], rd, 3'b001, rd, 7'b0010011}, 1'b0);
                9: add_half({3'b100, 1'b0, rd, rs2, 2'b10},
                            {7'd0, rs2, 5'd0, 3'b000, rd, 7'b0110011}, 1'b0);
                10: add_half({3'b100, 1'b1, rd, rs2, 2'b10},
                             {7'd0, rs2, rd, 3'b000, rd, 7'b0110011}, 1'b0);
                13: begin
                    // zero parcel, quadrant 0, or c.j.
                    case ($urandom_range(2, 0))
                        0: w[15:0] = 16'h0000;
                        1: w[15:0] = {14'($urandom), 2'b00};
                        default: w[15:0] = {3'b101, 11'($urandom), 2'b01};
                    endcase
                    add_half(w[15:0], 32'd0, 1'b1);
                end
                default: begin
                    w[1:0] = 2'b11;
                    add_word(w);
                end
            endcase
        end
        // little-endian parcels, two per word.
        for (int i = 0; i < halves.size(); i++) begin
            rom[i/2][16*(i%2) +: 16] = halves[i];
        end
        n_prog = N_WIDE + N_MIXED;
    endtask

    // every output must match the next expected instruction, in order.
    always @(negedge clk) begin : monitor
        rvc_pkg::decoded_inst_t want;
        if (checking) begin
            assert (out_inst.valid === run_q)
                else stop_on_error($sformatf("mismatch out_inst.valid: got %h expected %h",
                                             out_inst.valid, run_q));
            if (out_inst.valid) begin
                assert (exp_q.size() > 0)
                    else stop_on_error("an instruction came out after the stream ended");
                want = exp_q.pop_front();
                assert (out_inst.inst === want.inst)
                    else stop_on_error($sformatf("mismatch out_inst.inst: got %h expected %h",
                                                 out_inst.inst, want.inst));
                assert (out_inst.compressed === want.compressed)
                    else stop_on_error($sformatf(
                        "mismatch out_inst.compressed: got %h expected %h",
                        out_inst.compressed, want.compressed));
                assert (out_inst.illegal === want.illegal)
                    else stop_on_error($sformatf("mismatch out_inst.illegal: got %h expected %h",
                                                 out_inst.illegal, want.illegal));
                n_seen++;
                // parcels taken from memory so far.
                n_halves += want.compressed ? 1 : 2;
            end
        end
    end

    initial begin
        int cycles;
        int idle_left;
        int want_words;
        clk       = 1'b0;
        nrst      = 1'b0;
        run       = 1'b0;
        checking  = 1'b0;
        n_seen    = 0;
        n_halves  = 0;
        idle_left = 0;
        void'($urandom(32'h555d_a9a8));
        build_program();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        nrst     = 1'b1;
        checking = 1'b1;
        // idle after reset.
        repeat (3) begin
            @(negedge clk);
            assert (out_inst.valid === 1'b0)
                else stop_on_error($sformatf("mismatch out_inst.valid: got %h expected 0",
                                             out_inst.valid));
            assert (imem_addr === rvc_pkg::RESET_ADDR)
                else stop_on_error($sformatf("mismatch imem_addr: got %h expected %h",
                                             imem_addr, rvc_pkg::RESET_ADDR));
        end
        @(posedge clk);
        #2;
        run    = 1'b1;
        cycles = 0;
        while (n_seen < n_prog) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > RUN_LIMIT) begin
                stop_on_error("timeout while waiting for the program to come out");
            end else if (idle_left > 0) begin
                run = 1'b0;
                idle_left--;
            end else begin
                run = 1'b1;
                // idle stretches start once the 32-bit opening is through.
                if (n_seen >= N_WIDE && $urandom_range(15, 0) == 0) begin
                    idle_left = $urandom_range(6, 1);
                end
            end
        end
        run = 1'b0;
        // instructions already in flight still pass the monitor.
        repeat (DRAIN_CYCLES) @(posedge clk);
        // the address stands just past the last word with a consumed parcel.
        want_words = (n_halves + 1) / 2;
        if (imem_addr !== want_words[rvc_pkg::ADDR_W-1:0]) begin
            stop_on_error($sformatf("mismatch imem_addr: got %h expected %h", imem_addr,
                                    want_words[rvc_pkg::ADDR_W-1:0]));
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

/* hw/fetch_top.sv */
`timescale 1ns/10ps

module fetch_top (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       run,
    output logic [rvc_pkg::ADDR_W-1:0] imem_addr,
    input  logic [rvc_pkg::XLEN-1:0]   imem_data,
    output rvc_pkg::decoded_inst_t     out_inst
);

    rvc_pkg::fetch_word_t   word;
    rvc_pkg::aligned_inst_t aligned;
    logic                   stall;

    // word address and fetched word.
    fetch_counter i_fetch (
        .clk       (clk),
        .nrst      (nrst),
        .run       (run),
        .stall     (stall),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .word      (word)
    );

    // splits words into 16-bit and 32-bit instructions.
    halfword_aligner i_align (
        .clk   (clk),
        .nrst  (nrst),
        .word  (word),
        .stall (stall),
        .inst  (aligned)
    );

    // expansion and output register toward decode.
    rvc_expander i_expand (
        .clk      (clk),
        .nrst     (nrst),
        .inst     (aligned),
        .out_inst (out_inst)
    );

endmodule

/* hw/rvc_expander.sv */
`timescale 1ns/10ps

module rvc_expander (
    input  logic                   clk,
    input  logic                   nrst,
    input  rvc_pkg::aligned_inst_t inst,
    output rvc_pkg::decoded_inst_t out_inst
);

    logic [rvc_pkg::HALF-1:0] c;
    logic [1:0]               quad;
    logic [2:0]               c_f3;
    logic [4:0]               rd;
    logic [4:0]               rs2;
    logic [5:0]               imm6;
    logic [11:0]              imm12;
    logic [19:0]              imm20;
    logic                     legal;
    logic [rvc_pkg::XLEN-1:0] expanded;
    rvc_pkg::decoded_inst_t   exp_inst;

    // compressed fields used by the supported subset.
    assign c     = inst.bits[rvc_pkg::HALF-1:0];
    assign quad  = c[1:0];
    assign c_f3  = c[15:13];
    assign rd    = c[11:7];
    assign rs2   = c[6:2];
    assign imm6  = {c[12], c[6:2]};

    // sign extension of the 6-bit immediate.
    assign imm12 = {{6{imm6[5]}}, imm6};
    assign imm20 = {{14{imm6[5]}}, imm6};

    always_comb begin
        legal    = 1'b0;
        expanded = '0;
        case (quad)
            rvc_pkg::CQ1: begin
                case (c_f3)
                    rvc_pkg::C3_ADDI: begin
                        legal    = 1'b1;
                        expanded = {imm12, rd, rvc_pkg::F3_ADD, rd, rvc_pkg::OP_IMM};
                    end
                    rvc_pkg::C3_LI: begin
                        legal    = 1'b1;
                        expanded = {imm12, 5'd0, rvc_pkg::F3_ADD, rd, rvc_pkg::OP_IMM};
                    end
                    rvc_pkg::C3_LUI: begin
                        // rd of x2 is c.addi16sp, outside the subset.
                        if (rd != 5'd0 && rd != 5'd2 && imm6 != 6'd0) begin
                            legal    = 1'b1;
                            expanded = {imm20, rd, rvc_pkg::OP_LUI};
                        end
                    end
                    default: begin
                        legal = 1'b0;
                    end
                endcase
            end
            rvc_pkg::CQ2: begin
                case (c_f3)
                    rvc_pkg::C3_SLLI: begin
                        // shamt[5] is reserved on RV32.
                        if (!c[12]) begin
                            legal    = 1'b1;
                            expanded = {7'd0, imm6[4:0], rd, rvc_pkg::F3_SLL, rd,
                                        rvc_pkg::OP_IMM};
                        end
                    end
                    rvc_pkg::C3_MVADD: begin
                        // rs2 of x0 is c.jr, c.jalr or c.ebreak.
                        if (rs2 != 5'd0) begin
                            legal = 1'b1;
                            if (c[12]) begin
                                expanded = {7'd0, rs2, rd, rvc_pkg::F3_ADD, rd,
                                            rvc_pkg::OP_REG};
                            end else begin
                                expanded = {7'd0, rs2, 5'd0, rvc_pkg::F3_ADD, rd,
                                            rvc_pkg::OP_REG};
                            end
                        end
                    end
                    default: begin
                        legal = 1'b0;
                    end
                endcase
            end
            default: begin
                // quadrant 0 and everything else, the zero parcel included.
                legal = 1'b0;
            end
        endcase
    end

    always_comb begin
        exp_inst.valid      = inst.valid;
        exp_inst.compressed = inst.compressed;
        if (inst.compressed) begin
            exp_inst.illegal = !legal;
            exp_inst.inst    = expanded;
        end else begin
            // full-length instructions pass untouched.
            exp_inst.illegal = 1'b0;
            exp_inst.inst    = inst.bits;
        end
    end

    always_ff @(posedge clk) begin
        out_inst <= exp_inst;
        if (!nrst) begin
            out_inst.valid <= 1'b0;
        end
    end

endmodule

/* hw/halfword_aligner.sv */
`timescale 1ns/10ps

module halfword_aligner (
    input  logic                   clk,
    input  logic                   nrst,
    input  rvc_pkg::fetch_word_t   word,
    output logic                   stall,
    output rvc_pkg::aligned_inst_t inst
);

    logic [rvc_pkg::HALF-1:0] residue;
    logic [rvc_pkg::HALF-1:0] residue_nxt;
    logic                     full;
    logic                     full_nxt;
    logic [rvc_pkg::HALF-1:0] lo_half;
    logic [rvc_pkg::HALF-1:0] hi_half;
    logic                     lo_comp;
    logic                     res_comp;

    assign lo_half = word.data[rvc_pkg::HALF-1:0];
    assign hi_half = word.data[rvc_pkg::XLEN-1:rvc_pkg::HALF];

    // a parcel is compressed unless its two low bits are both set.
    assign lo_comp  = (lo_half[1:0] != 2'b11);
    assign res_comp = (residue[1:0] != 2'b11);

    always_comb begin
        inst        = '0;
        stall       = 1'b0;
        residue_nxt = residue;
        full_nxt    = full;
        if (word.valid) begin
            inst.valid = 1'b1;
            if (!full) begin
                if (lo_comp) begin
                    // low parcel goes out, high parcel waits for the next word.
                    inst.compressed = 1'b1;
                    inst.bits       = {{rvc_pkg::HALF{1'b0}}, lo_half};
                    residue_nxt     = hi_half;
                    full_nxt        = 1'b1;
                end else begin
                    inst.bits = word.data;
                end
            end else if (res_comp) begin
                // only the residue is used, the word is asked for again.
                inst.compressed = 1'b1;
                inst.bits       = {{rvc_pkg::HALF{1'b0}}, residue};
                full_nxt        = 1'b0;
                stall           = 1'b1;
            end else begin
                // 32-bit instruction straddling the word boundary.
                inst.bits   = {lo_half, residue};
                residue_nxt = hi_half;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            full <= 1'b0;
        end else begin
            full <= full_nxt;
        end
    end

    always_ff @(posedge clk) begin
        residue <= residue_nxt;
    end

endmodule

/* hw/fetch_counter.sv */
`timescale 1ns/10ps

module fetch_counter (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       run,
    input  logic                       stall,
    output logic [rvc_pkg::ADDR_W-1:0] imem_addr,
    input  logic [rvc_pkg::XLEN-1:0]   imem_data,
    output rvc_pkg::fetch_word_t       word
);

    logic [rvc_pkg::ADDR_W-1:0] addr;
    logic                       advance;

    // the word is consumed unless the aligner asks for it again.
    assign advance = run && !stall;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            addr <= rvc_pkg::RESET_ADDR;
        end else if (advance) begin
            // wraps at the top of the space.
            addr <= addr + 1'b1;
        end
    end

    assign imem_addr = addr;

    // memory answers in the same cycle.
    assign word.valid = run;
    assign word.data  = imem_data;

endmodule

/* hw/rvc_pkg.sv */
package rvc_pkg;

    // instruction and fetch word width.
    localparam int XLEN = 32;

    // one RVC parcel.
    localparam int HALF = 16;

    // word address, 4 KB of instruction space.
    localparam int ADDR_W = 10;

    // first word fetched after reset.
    localparam logic [ADDR_W-1:0] RESET_ADDR = '0;

    // 32-bit major opcodes produced by the expander.
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_LUI = 7'b0110111;

    // funct3 of the expanded forms.
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;

    // compressed quadrants, taken from bits [1:0].
    localparam logic [1:0] CQ1 = 2'b01;
    localparam logic [1:0] CQ2 = 2'b10;

    // compressed funct3, taken from bits [15:13].
    localparam logic [2:0] C3_ADDI  = 3'b000;
    localparam logic [2:0] C3_LI    = 3'b010;
    localparam logic [2:0] C3_LUI   = 3'b011;
    localparam logic [2:0] C3_SLLI  = 3'b000;
    localparam logic [2:0] C3_MVADD = 3'b100;

    // word as read from instruction memory.
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] data;
    } fetch_word_t;

    // one instruction out of the aligner.
    // upper half of bits is zero for a compressed instruction.
    typedef struct packed {
        logic            valid;
        logic            compressed;
        logic [XLEN-1:0] bits;
    } aligned_inst_t;

    // expanded instruction handed to decode.
    typedef struct packed {
        logic            valid;
        logic            compressed;
        logic            illegal;
        logic [XLEN-1:0] inst;
    } decoded_inst_t;

endpackage
